//--- rtl/rubik_pkg.sv
// ============================
// shared widths, data types, register map
// and buffer depth for the reshape engine
// ============================
`default_nettype none

package rubik_pkg;

  // ============================
  // data and address types
  // ============================
  typedef logic [31:0] addr_t;      // word address
  typedef logic [31:0] word_t;      // one beat, four byte lanes
  typedef logic [2:0]  reg_addr_t;  // register index
  typedef logic [31:0] reg_data_t;  // register payload
  typedef logic [15:0] blk_cnt_t;   // number of blocks
  typedef logic [3:0]  credit_t;    // reads in flight, 0..8

  // block shape is square
  localparam int LANES = 4;         // bytes per beat and beats per block

  // response fifo depth doubles as credit limit
  localparam int RD_BUF_DEPTH = 8;

  // ============================
  // register map
  // ============================
  localparam reg_addr_t REG_OP_EN        = 3'd0;  // start and busy bit
  localparam reg_addr_t REG_SRC_BASE     = 3'd1;  // first source word
  localparam reg_addr_t REG_DST_BASE     = 3'd2;  // plane 0 base
  localparam reg_addr_t REG_PLANE_STRIDE = 3'd3;  // distance between planes
  localparam reg_addr_t REG_NUM_BLOCKS   = 3'd4;  // blocks per op

endpackage

`default_nettype wire

//--- rtl/rubik_regfile.sv
// ============================
// config registers, op enable level
// and done interrupt
// ============================
`timescale 1ns/1ps
`default_nettype none

module rubik_regfile (
  input  wire                       core_clk,
  input  wire                       rst_n,
  input  wire                       reg_wr_en,     // single cycle write
  input  wire                       reg_rd_en,     // single cycle read
  input  wire rubik_pkg::reg_addr_t reg_addr,
  input  wire rubik_pkg::reg_data_t reg_wdata,
  input  wire                       op_done,       // last completion
  output rubik_pkg::reg_data_t      reg_rdata,
  output logic                      reg_rd_valid,
  output logic                      op_start,      // one cycle start
  output rubik_pkg::addr_t          src_base,
  output rubik_pkg::addr_t          dst_base,
  output rubik_pkg::addr_t          plane_stride,
  output rubik_pkg::blk_cnt_t       num_blocks,
  output logic                      done_intr
);
  import rubik_pkg::*;

  logic      op_en;         // busy level, self clearing
  reg_data_t num_blocks_q;  // whole word kept for readback
  reg_data_t rd_mux;

  // start only from idle
  assign op_start   = reg_wr_en && (reg_addr == REG_OP_EN) && reg_wdata[0] && !op_en;
  assign num_blocks = num_blocks_q[$bits(blk_cnt_t)-1:0];  // low half drives engine

  // ============================
  // writes and op enable
  // ============================
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      op_en        <= 1'b0;
      src_base     <= '0;
      dst_base     <= '0;
      plane_stride <= '0;
      num_blocks_q <= '0;
      done_intr    <= 1'b0;
      reg_rd_valid <= 1'b0;
    end else begin
      if (op_start) begin
        op_en <= 1'b1;
      end else if (op_done) begin
        op_en <= 1'b0;                    // cleared with the interrupt
      end
      if (reg_wr_en) begin
        case (reg_addr)
          REG_SRC_BASE:     src_base     <= reg_wdata;
          REG_DST_BASE:     dst_base     <= reg_wdata;
          REG_PLANE_STRIDE: plane_stride <= reg_wdata;
          REG_NUM_BLOCKS:   num_blocks_q <= reg_wdata;
          default: ;                      // op enable handled above
        endcase
      end
      done_intr    <= op_done;            // one cycle behind op_done
      reg_rd_valid <= reg_rd_en;
    end
  end

  // read decode
  always_comb begin
    case (reg_addr)
      REG_OP_EN:        rd_mux = reg_data_t'(op_en);
      REG_SRC_BASE:     rd_mux = src_base;
      REG_DST_BASE:     rd_mux = dst_base;
      REG_PLANE_STRIDE: rd_mux = plane_stride;
      REG_NUM_BLOCKS:   rd_mux = num_blocks_q;
      default:          rd_mux = '0;      // unmapped reads zero
    endcase
  end

  always_ff @(posedge core_clk) begin
    if (reg_rd_en) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rubik_seq_gen.sv
// ============================
// read request sequencer with credit limit
// ============================
`timescale 1ns/1ps
`default_nettype none

module rubik_seq_gen (
  input  wire                      core_clk,
  input  wire                      rst_n,
  input  wire                      op_start,
  input  wire rubik_pkg::addr_t    src_base,
  input  wire rubik_pkg::blk_cnt_t num_blocks,
  input  wire                      rd_req_ready,
  input  wire                      credit_return,  // one per fifo pop
  output logic                     rd_req_valid,
  output rubik_pkg::addr_t         rd_req_addr
);
  import rubik_pkg::*;

  typedef enum logic {IDLE, RUN} seq_state_t;

  seq_state_t                  state;
  logic [$bits(blk_cnt_t)+1:0] reads_left;     // incl. the pending one
  logic [$bits(blk_cnt_t)+1:0] left_nxt;
  credit_t                     credits_used;   // accepted, not yet popped
  credit_t                     credits_nxt;
  logic                        rd_fire;
  logic                        credit_ok;

  assign rd_fire   = rd_req_valid && rd_req_ready;
  assign left_nxt  = rd_fire ? reads_left - 1'b1 : reads_left;
  assign credit_ok = credits_nxt < credit_t'(RD_BUF_DEPTH);  // room for one more

  always_comb begin
    credits_nxt = credits_used;
    if (rd_fire) begin
      credits_nxt = credits_nxt + 1'b1;
    end
    if (credit_return) begin
      credits_nxt = credits_nxt - 1'b1;
    end
  end

  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      state        <= IDLE;
      rd_req_valid <= 1'b0;
      rd_req_addr  <= '0;
      reads_left   <= '0;
      credits_used <= '0;
    end else begin
      credits_used <= credits_nxt;
      case (state)
        IDLE: begin
          if (op_start && (num_blocks != '0)) begin
            state        <= RUN;
            rd_req_addr  <= src_base;
            reads_left   <= {num_blocks, 2'b00};  // four beats per block
            rd_req_valid <= credit_ok;
          end
        end
        RUN: begin
          reads_left <= left_nxt;
          if (rd_fire) begin
            rd_req_addr <= rd_req_addr + 1'b1;    // next source word
          end
          if (!rd_req_valid || rd_fire) begin
            rd_req_valid <= (left_nxt != '0) && credit_ok;  // hold while pending
          end
          if (left_nxt == '0) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/rubik_rd_buf.sv
// ============================
// read response fifo, returns credits
// ============================
`timescale 1ns/1ps
`default_nettype none

module rubik_rd_buf (
  input  wire                   core_clk,
  input  wire                   rst_n,
  input  wire                   rd_rsp_valid,   // no ready, credits cover space
  input  wire rubik_pkg::word_t rd_rsp_data,
  input  wire                   beat_ready,
  output logic                  beat_valid,
  output rubik_pkg::word_t      beat_data,
  output logic                  credit_return   // pulse per pop
);
  import rubik_pkg::*;

  word_t                           mem [RD_BUF_DEPTH];
  logic [$clog2(RD_BUF_DEPTH)-1:0] wr_ptr;   // wraps at depth
  logic [$clog2(RD_BUF_DEPTH)-1:0] rd_ptr;
  credit_t                         count;    // entries held
  logic                            push;
  logic                            pop;

  assign push          = rd_rsp_valid;
  assign pop           = beat_valid && beat_ready;
  assign beat_valid    = (count != '0);      // registered count, next cycle visible
  assign beat_data     = mem[rd_ptr];
  assign credit_return = pop;

  // ============================
  // pointers and occupancy
  // ============================
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge core_clk) begin
    if (push) begin
      mem[wr_ptr] <= rd_rsp_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rubik_rf_core.sv
// ============================
// four beat block buffer, byte transpose
// ============================
`timescale 1ns/1ps
`default_nettype none

module rubik_rf_core (
  input  wire                   core_clk,
  input  wire                   rst_n,
  input  wire                   beat_valid,
  input  wire rubik_pkg::word_t beat_data,
  input  wire                   plane_ready,
  output logic                  beat_ready,
  output logic                  plane_valid,
  output rubik_pkg::word_t      plane_data
);
  import rubik_pkg::*;

  typedef enum logic {FILL, DRAIN} rf_state_t;

  rf_state_t                 state;
  logic [$clog2(LANES)-1:0]  idx;               // beat in fill, plane in drain
  logic [LANES-1:0][7:0]     blk_q [LANES];     // [source beat][byte lane]
  logic                      beat_fire;
  logic                      plane_fire;
  logic                      idx_last;

  assign beat_ready  = (state == FILL);
  assign plane_valid = (state == DRAIN);
  assign beat_fire   = beat_valid && beat_ready;
  assign plane_fire  = plane_valid && plane_ready;
  assign idx_last    = (int'(idx) == LANES - 1);

  // plane p takes byte p of every beat, beat k into lane k
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      plane_data[8*k +: 8] = blk_q[k][idx];
    end
  end

  // ============================
  // fill / drain control
  // ============================
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      state <= FILL;
      idx   <= '0;
    end else begin
      case (state)
        FILL: begin
          if (beat_fire) begin
            idx <= idx + 1'b1;           // wraps to 0 on last beat
            if (idx_last) begin
              state <= DRAIN;
            end
          end
        end
        DRAIN: begin
          if (plane_fire) begin
            idx <= idx + 1'b1;
            if (idx_last) begin
              state <= FILL;             // next block may wait in fifo
            end
          end
        end
        default: state <= FILL;
      endcase
    end
  end

  // block storage
  always_ff @(posedge core_clk) begin
    if (beat_fire) begin
      blk_q[idx] <= beat_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rubik_wr_req.sv
// ============================
// write address generation, write request stage
// and completion counting
// ============================
`timescale 1ns/1ps
`default_nettype none

module rubik_wr_req (
  input  wire                      core_clk,
  input  wire                      rst_n,
  input  wire                      op_start,
  input  wire rubik_pkg::addr_t    dst_base,
  input  wire rubik_pkg::addr_t    plane_stride,
  input  wire rubik_pkg::blk_cnt_t num_blocks,
  input  wire                      plane_valid,
  input  wire rubik_pkg::word_t    plane_data,
  input  wire                      wr_req_ready,
  input  wire                      wr_rsp_complete,  // one per accepted write
  output logic                     plane_ready,
  output logic                     wr_req_valid,
  output rubik_pkg::addr_t         wr_req_addr,
  output rubik_pkg::word_t         wr_req_data,
  output logic                     op_done
);
  import rubik_pkg::*;

  logic [$clog2(LANES)-1:0]    plane_idx;   // output surface
  blk_cnt_t                    blk_idx;     // word within surface
  logic [$bits(blk_cnt_t)+1:0] cmpl_cnt;    // completions so far
  logic                        plane_fire;
  logic                        wr_fire;

  assign wr_fire     = wr_req_valid && wr_req_ready;
  assign plane_ready = !wr_req_valid || wr_req_ready;   // stage empty or leaving
  assign plane_fire  = plane_valid && plane_ready;

  // combinational on the final completion
  assign op_done = wr_rsp_complete && ((cmpl_cnt + 1'b1) == {num_blocks, 2'b00});

  // ============================
  // counters and request valid
  // ============================
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      plane_idx    <= '0;
      blk_idx      <= '0;
      cmpl_cnt     <= '0;
      wr_req_valid <= 1'b0;
    end else begin
      if (op_start) begin
        plane_idx <= '0;
        blk_idx   <= '0;
        cmpl_cnt  <= '0;
      end else begin
        if (plane_fire) begin
          plane_idx <= plane_idx + 1'b1;
          if (int'(plane_idx) == LANES - 1) begin
            blk_idx <= blk_idx + 1'b1;     // all planes of block sent
          end
        end
        if (wr_rsp_complete) begin
          cmpl_cnt <= cmpl_cnt + 1'b1;
        end
      end
      if (plane_fire) begin
        wr_req_valid <= 1'b1;
      end else if (wr_fire) begin
        wr_req_valid <= 1'b0;
      end
    end
  end

  // payload, base + plane * stride + block
  always_ff @(posedge core_clk) begin
    if (plane_fire) begin
      wr_req_data <= plane_data;
      wr_req_addr <= dst_base + plane_stride * addr_t'(plane_idx) + addr_t'(blk_idx);
    end
  end

endmodule

`default_nettype wire

//--- rtl/rubik.sv
// ============================
// reshape engine top, regfile plus
// read, buffer and write datapath
// ============================
`timescale 1ns/1ps
`default_nettype none

module rubik (
  input  wire                       core_clk,
  input  wire                       rst_n,
  // register port
  input  wire                       reg_wr_en,
  input  wire                       reg_rd_en,
  input  wire rubik_pkg::reg_addr_t reg_addr,
  input  wire rubik_pkg::reg_data_t reg_wdata,
  output wire rubik_pkg::reg_data_t reg_rdata,
  output wire                       reg_rd_valid,
  // memory read
  output wire                       rd_req_valid,
  input  wire                       rd_req_ready,
  output wire rubik_pkg::addr_t     rd_req_addr,
  input  wire                       rd_rsp_valid,
  input  wire rubik_pkg::word_t     rd_rsp_data,
  // memory write
  output wire                       wr_req_valid,
  input  wire                       wr_req_ready,
  output wire rubik_pkg::addr_t     wr_req_addr,
  output wire rubik_pkg::word_t     wr_req_data,
  input  wire                       wr_rsp_complete,
  output wire                       done_intr
);
  import rubik_pkg::*;

  // ============================
  // internal links
  // ============================
  wire           op_start;       // regfile to seq gen and write path
  wire           op_done;        // write path to regfile
  wire addr_t    src_base;
  wire addr_t    dst_base;
  wire addr_t    plane_stride;
  wire blk_cnt_t num_blocks;
  wire           credit_return;  // fifo pop back to seq gen
  wire           beat_valid;     // fifo to block buffer
  wire           beat_ready;
  wire word_t    beat_data;
  wire           plane_valid;    // block buffer to write path
  wire           plane_ready;
  wire word_t    plane_data;

  // config and interrupt
  rubik_regfile u_regfile (.*);

  // read side
  rubik_seq_gen u_seq_gen (.*);
  rubik_rd_buf  u_rd_buf  (.*);

  // reorder
  rubik_rf_core u_rf_core (.*);

  // write side
  rubik_wr_req  u_wr_req  (.*);

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
// ============================
// free running clock, 100 ns period
// ============================
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic core_clk
);

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;  // half period
  end

endmodule

`default_nettype wire

//--- testbench/rubik_sva.sv
// ============================
// handshake, credit and reset assertions
// bound to the engine top
// ============================
`timescale 1ns/1ps
`default_nettype none

module rubik_sva (
  input wire                   core_clk,
  input wire                   rst_n,
  input wire                   rd_req_valid,
  input wire                   rd_req_ready,
  input wire rubik_pkg::addr_t rd_req_addr,
  input wire                   rd_rsp_valid,
  input wire                   wr_req_valid,
  input wire                   wr_req_ready,
  input wire rubik_pkg::addr_t wr_req_addr,
  input wire rubik_pkg::word_t wr_req_data,
  input wire                   reg_rd_valid,
  input wire                   done_intr
);
  import rubik_pkg::*;

  int fail_cnt = 0;  // polled by the testbench
  int in_flight;     // accepted reads minus responses

  always @(posedge core_clk) begin
    if (!rst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(rd_req_valid && rd_req_ready) - int'(rd_rsp_valid);
    end
  end

  // ============================
  // properties
  // ============================
  rd_req_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req_addr))
    else begin
      $error("read request dropped or changed before its handshake");
      fail_cnt++;
    end

  wr_req_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
    wr_req_valid && !wr_req_ready |=>
      wr_req_valid && $stable(wr_req_addr) && $stable(wr_req_data))
    else begin
      $error("write request dropped or changed before its handshake");
      fail_cnt++;
    end

  rd_credit_limit: assert property (@(posedge core_clk) disable iff (!rst_n)
    in_flight <= RD_BUF_DEPTH)
    else begin
      $error("more reads outstanding than the response buffer holds");
      fail_cnt++;
    end

  // outputs quiet out of reset
  reset_idle: assert property (@(posedge core_clk)
    !rst_n |=> !rd_req_valid && !wr_req_valid && !reg_rd_valid && !done_intr)
    else begin
      $error("an output was high right after reset");
      fail_cnt++;
    end

  done_single: assert property (@(posedge core_clk) disable iff (!rst_n)
    done_intr |=> !done_intr)
    else begin
      $error("done interrupt longer than one cycle");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- testbench/tb_rubik.sv
// ============================
// engine testbench, memory model with random
// readies and latency, checks and watchdog
// ============================
`timescale 1ns/1ps
`default_nettype none

module tb_rubik;
  import rubik_pkg::*;

  localparam int NUM_OPS         = 3;
  localparam int TOTAL_BLOCKS    = 3 + 8 + 1;  // blocks over all ops below
  localparam int WATCHDOG_CYCLES = TOTAL_BLOCKS * LANES * 40 + NUM_OPS * 300 + 20;

  wire       core_clk;
  logic      rst_n;
  logic      reg_wr_en;
  logic      reg_rd_en;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  wire reg_data_t reg_rdata;
  wire       reg_rd_valid;
  wire       rd_req_valid;
  logic      rd_req_ready;
  wire addr_t rd_req_addr;
  logic      rd_rsp_valid;
  word_t     rd_rsp_data;
  wire       wr_req_valid;
  logic      wr_req_ready;
  wire addr_t wr_req_addr;
  wire word_t wr_req_data;
  logic      wr_rsp_complete;
  wire       done_intr;

  int    seed = 39;
  int    cyc;            // posedges since reset release
  int    last_cmpl_cyc;  // edge of the final completion
  int    total;          // beats in the current op
  int    rd_cnt;
  int    wr_cnt;
  int    cmpl_cnt;
  int    done_cnt;
  addr_t cur_src;
  addr_t cur_dst;
  addr_t cur_stride;
  addr_t rd_addr_q[$];   // accepted reads, in order
  int    rd_due_q[$];    // cycle each response may return
  int    cmpl_due_q[$];  // cycle each completion may fire

  tb_clk_gen clk_gen_inst (.core_clk(core_clk));

  rubik rubik_inst (.*);

  bind rubik rubik_sva sva_inst (
    .core_clk(core_clk), .rst_n(rst_n),
    .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready), .rd_req_addr(rd_req_addr),
    .rd_rsp_valid(rd_rsp_valid),
    .wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
    .wr_req_addr(wr_req_addr), .wr_req_data(wr_req_data),
    .reg_rd_valid(reg_rd_valid), .done_intr(done_intr)
  );

  // ============================
  // reference model and helpers
  // ============================
  function automatic word_t mem_word(addr_t a);
    word_t w;
    for (int j = 0; j < LANES; j++) begin
      w[8*j +: 8] = 8'(4 * a + addr_t'(j));  // byte j of word a
    end
    return w;
  endfunction

  // byte k of plane p = byte p of source word 4b + k
  function automatic word_t plane_word(int b, int p);
    word_t w;
    word_t src;
    for (int k = 0; k < LANES; k++) begin
      src         = mem_word(cur_src + addr_t'(LANES * b + k));
      w[8*k +: 8] = src[8*p +: 8];
    end
    return w;
  endfunction

  task automatic stop_on_failure(string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else
      stop_on_failure($sformatf("CHECK FAILED %s expected 0x%08h actual 0x%08h",
                                name, exp, act));
  endtask

  task automatic write_reg(reg_addr_t a, reg_data_t d);
    @(negedge core_clk);
    reg_wr_en = 1'b1;
    reg_addr  = a;
    reg_wdata = d;
    @(negedge core_clk);
    reg_wr_en = 1'b0;
  endtask

  task automatic read_reg(string name, reg_addr_t a, reg_data_t exp);
    @(negedge core_clk);
    reg_rd_en = 1'b1;
    reg_addr  = a;
    @(negedge core_clk);
    reg_rd_en = 1'b0;                        // data valid one cycle later
    check_eq({name, "_valid"}, 1, reg_rd_valid);
    check_eq(name, exp, reg_rdata);
  endtask

  task automatic run_op(addr_t src, addr_t dst, addr_t stride, blk_cnt_t nblk);
    cur_src       = src;
    cur_dst       = dst;
    cur_stride    = stride;
    total         = int'(nblk) * LANES;
    rd_cnt        = 0;
    wr_cnt        = 0;
    cmpl_cnt      = 0;
    done_cnt      = 0;
    last_cmpl_cyc = -10;
    write_reg(REG_SRC_BASE, src);
    write_reg(REG_DST_BASE, dst);
    write_reg(REG_PLANE_STRIDE, stride);
    write_reg(REG_NUM_BLOCKS, reg_data_t'(nblk));
    read_reg("src_base", REG_SRC_BASE, src);
    read_reg("dst_base", REG_DST_BASE, dst);
    read_reg("plane_stride", REG_PLANE_STRIDE, stride);
    read_reg("num_blocks", REG_NUM_BLOCKS, reg_data_t'(nblk));
    write_reg(REG_OP_EN, 1);
    check_eq("start_latency", 1, rd_req_valid);  // first read right after start edge
    read_reg("op_en_busy", REG_OP_EN, 1);
    while (done_cnt == 0) begin
      @(negedge core_clk);                   // watchdog bounds this
    end
    repeat (8) @(negedge core_clk);          // room for a stray second pulse
    check_eq("done_count", 1, done_cnt);
    check_eq("read_count", total, rd_cnt);
    check_eq("write_count", total, wr_cnt);
    check_eq("complete_count", total, cmpl_cnt);
    read_reg("op_en_idle", REG_OP_EN, 0);
  endtask

  // ============================
  // memory model and monitor
  // ============================
  always @(posedge core_clk) begin
    if (rst_n) begin
      if (rd_req_valid && rd_req_ready) begin
        check_eq("read_addr", cur_src + addr_t'(rd_cnt), rd_req_addr);
        rd_addr_q.push_back(rd_req_addr);
        rd_due_q.push_back(cyc + 1 + ($random(seed) & 15));  // 0..15 extra cycles
        rd_cnt++;
      end
      if (wr_req_valid && wr_req_ready) begin
        check_eq("write_addr",
                 cur_dst + cur_stride * addr_t'(wr_cnt % LANES) + addr_t'(wr_cnt / LANES),
                 wr_req_addr);
        check_eq("write_data", plane_word(wr_cnt / LANES, wr_cnt % LANES), wr_req_data);
        cmpl_due_q.push_back(cyc + 1 + ($random(seed) & 3));
        wr_cnt++;
      end
      if (wr_rsp_complete) begin
        cmpl_cnt++;
        if (cmpl_cnt == total) begin
          last_cmpl_cyc = cyc;
        end
      end
      if (done_intr) begin
        done_cnt++;
      end
      cyc++;
    end
  end

  // responses, completions and readies change on the falling edge
  always @(negedge core_clk) begin
    if (!rst_n) begin
      rd_req_ready    = 1'b0;
      wr_req_ready    = 1'b0;
      rd_rsp_valid    = 1'b0;
      wr_rsp_complete = 1'b0;
    end else begin
      rd_req_ready    = ($random(seed) & 3) != 0;  // mostly ready
      wr_req_ready    = ($random(seed) & 1) != 0;  // half the time
      rd_rsp_valid    = 1'b0;
      wr_rsp_complete = 1'b0;
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
        rd_rsp_valid = 1'b1;
        rd_rsp_data  = mem_word(rd_addr_q.pop_front());
        void'(rd_due_q.pop_front());
      end
      if (cmpl_due_q.size() > 0 && cmpl_due_q[0] <= cyc) begin
        wr_rsp_complete = 1'b1;
        void'(cmpl_due_q.pop_front());
      end
    end
  end

  // done exactly one edge after the final completion
  done_timing: assert property (@(posedge core_clk) disable iff (!rst_n)
    done_intr == (cyc == last_cmpl_cyc + 1))
    else stop_on_failure("done_intr not one cycle after the last write completion");

  always @(negedge core_clk) begin
    if (rubik_inst.sva_inst.fail_cnt != 0) begin
      stop_on_failure("a bound protocol assertion failed");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge core_clk);
    stop_on_failure("watchdog expired before all operations finished");
  end

  // ============================
  // main sequence
  // ============================
  initial begin
    rst_n           = 1'b0;
    reg_wr_en       = 1'b0;
    reg_rd_en       = 1'b0;
    reg_addr        = '0;
    reg_wdata       = '0;
    rd_req_ready    = 1'b0;
    rd_rsp_valid    = 1'b0;
    rd_rsp_data     = '0;
    wr_req_ready    = 1'b0;
    wr_rsp_complete = 1'b0;
    cyc             = 0;
    last_cmpl_cyc   = -10;
    total           = 0;
    repeat (10) @(posedge core_clk);         // ten edges in reset
    @(negedge core_clk);
    rst_n = 1'b1;
    run_op(32'h0000_0100, 32'h0000_4000, 32'h0000_0040, 16'd3);
    run_op(32'h0000_2345, 32'h0000_8000, 32'h0000_0100, 16'd8);
    run_op(32'h0000_fffe, 32'h0002_0000, 32'h0000_0011, 16'd1);  // source crosses 64k
    if (rubik_inst.sva_inst.fail_cnt != 0) begin
      stop_on_failure("a bound protocol assertion failed");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
rtl/rubik_pkg.sv
rtl/rubik_regfile.sv
rtl/rubik_seq_gen.sv
rtl/rubik_rd_buf.sv
rtl/rubik_rf_core.sv
rtl/rubik_wr_req.sv
rtl/rubik.sv
testbench/tb_clk_gen.sv
testbench/rubik_sva.sv
testbench/tb_rubik.sv

//--- Bender.yml
package:
  name: rubik

sources:
  - rtl/rubik_pkg.sv
  - rtl/rubik_regfile.sv
  - rtl/rubik_seq_gen.sv
  - rtl/rubik_rd_buf.sv
  - rtl/rubik_rf_core.sv
  - rtl/rubik_wr_req.sv
  - rtl/rubik.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/rubik_sva.sv
      - testbench/tb_rubik.sv
